//--- hw/predec_cfg.svh
`ifndef PREDEC_CFG_SVH
`define PREDEC_CFG_SVH

// *************************************************************************
// bundle geometry
// *************************************************************************

`define PARCEL_COUNT   15 // parcels per bundle
`define PARCEL_WIDTH   16 // bits per parcel
`define WINDOW_PARCELS 4  // 64 bit window

// *************************************************************************
// output lists
// *************************************************************************

`define SLOT_COUNT     12 // instruction slots
`define JUMP_COUNT     4  // jump slots
`define OFF_WIDTH      4  // parcel offset

`endif

//--- hw/predec_pkg.sv
`include "predec_cfg.svh"

package predecPkg;

  // one 256 bit bundle, parcel 0 in the low bits
  typedef struct packed {
    logic                                       spare;   // bit 255, ignored
    logic [`PARCEL_COUNT-1:0]                   endBits; // bits 254:240
    logic [`PARCEL_COUNT-1:0][`PARCEL_WIDTH-1:0] parcels; // bits 239:0
  } bundleT;

  typedef struct packed {
    logic indir;
    logic jump;
    logic alu;
    logic shift;
    logic mul;
    logic load;
    logic store;
    logic fpu;
    logic sys;
  } classT;

  typedef struct packed {
    logic [`WINDOW_PARCELS*`PARCEL_WIDTH-1:0] window;
    logic [`OFF_WIDTH-1:0]                    off;        // start parcel
    logic [`WINDOW_PARCELS-1:0]               lengthCode; // bit 0 set = long form
    classT                                    cls;
  } slotT;

  // stage 1 register
  typedef struct packed {
    logic [`PARCEL_COUNT-1:0][`PARCEL_WIDTH-1:0] parcels;
    logic [`PARCEL_COUNT-1:0]                   startMask;
    logic [`PARCEL_COUNT-1:0]                   jumpMask;
    slotT [`PARCEL_COUNT-1:0]                   slots; // one per parcel
    logic                                       error;
  } scanT;

  typedef struct packed {
    slotT [`SLOT_COUNT-1:0] slots;
    logic [`SLOT_COUNT-1:0] slotEn;
    slotT [`JUMP_COUNT-1:0] jumps;
    logic [`JUMP_COUNT-1:0] jumpEn;
    logic                   error;
    logic                   jumpOverflow;
  } predecOutT;

endpackage

//--- hw/predecClass.sv
`timescale 1ns/1ns

module predecClass import predecPkg::*; (
  input  logic [31:0] window,
  input  logic        longForm,
  output classT       cls
);

  logic [7:0] opcode;
  logic [5:0] shortOp;
  logic [2:0] jumpSub;
  classT      longCls;
  classT      shortCls;

  assign opcode  = window[7:0];
  assign shortOp = window[5:0];
  assign jumpSub = window[15:13]; // kind of opcode 182

  // *************************************************************************
  // long form, main opcode
  // *************************************************************************

  always_comb begin
    longCls = '0;
    case (opcode) inside
      [8'd0:8'd31]: begin
        longCls.alu = ~opcode[2];
        longCls.mul = opcode[2]; // bit 2 picks the multiplier
      end
      [8'd40:8'd45]: begin
        longCls.shift = 1'b1;
      end
      [8'd46:8'd53]: begin
        longCls.alu = 1'b1; // compare and test
      end
      [8'd64:8'd127]: begin
        longCls.load  = ~opcode[0];
        longCls.store = opcode[0];
      end
      [8'd160:8'd175]: begin
        longCls.jump = 1'b1; // cond jump, flags via alu
        longCls.alu  = 1'b1;
      end
      8'd180, 8'd181: begin
        longCls.jump = 1'b1;
      end
      8'd182: begin
        case (jumpSub)
          3'd0, 3'd3: begin
            longCls.jump  = 1'b1; // indirect and return
            longCls.indir = 1'b1;
          end
          3'd1, 3'd2: begin
            longCls.jump  = 1'b1; // call pushes the link
            longCls.store = 1'b1;
          end
          default: begin
            longCls = '0;
          end
        endcase
      end
      8'd240: begin
        longCls.fpu = 1'b1;
      end
      8'd255: begin
        longCls.sys = 1'b1;
      end
      default: begin
        longCls = '0;
      end
    endcase
  end

  // *************************************************************************
  // short form, 6 bit opcode
  // *************************************************************************

  always_comb begin
    shortCls = '0;
    case (shortOp) inside
      [6'd0:6'd19]: begin
        shortCls.alu = 1'b1;
      end
      [6'd48:6'd51]: begin
        shortCls.jump = 1'b1; // short cond jump
        shortCls.alu  = 1'b1;
      end
      default: begin
        shortCls = '0;
      end
    endcase
  end

  assign cls = longForm ? longCls : shortCls;

endmodule

//--- hw/slotCompact.sv
`timescale 1ns/1ns
`include "predec_cfg.svh"

module slotCompact #(
  parameter type itemT     = logic [7:0],
  parameter int  OUT_COUNT = 4
) (
  input  itemT [`PARCEL_COUNT-1:0] items,
  input  logic [`PARCEL_COUNT-1:0] flags,
  output itemT [OUT_COUNT-1:0]     picked,
  output logic [OUT_COUNT-1:0]     pickedEn,
  output logic                     overflow
);

  localparam int CNT_W = $clog2(`PARCEL_COUNT + 1);

  logic [`PARCEL_COUNT:0][CNT_W-1:0] prefix; // flags set below each position
  logic [CNT_W-1:0]                  total;

  always_comb begin
    prefix[0] = '0;
    for (int k = 0; k < `PARCEL_COUNT; k++) begin
      prefix[k+1] = prefix[k] + CNT_W'(flags[k]);
    end
  end

  assign total = prefix[`PARCEL_COUNT];

  // *************************************************************************
  // n-th flagged item per output
  // *************************************************************************

  always_comb begin
    for (int n = 0; n < OUT_COUNT; n++) begin
      picked[n] = '0; // empty slot reads zero
      for (int k = 0; k < `PARCEL_COUNT; k++) begin
        if (flags[k] && prefix[k] == CNT_W'(n)) begin
          picked[n] = items[k];
        end
      end
    end
  end

  always_comb begin
    for (int n = 0; n < OUT_COUNT; n++) begin
      pickedEn[n] = total > CNT_W'(n);
    end
  end

  assign overflow = total > CNT_W'(OUT_COUNT);

endmodule

//--- hw/parcelScan.sv
`timescale 1ns/1ns
`include "predec_cfg.svh"

module parcelScan import predecPkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  bundleT                inBundle,
  input  logic [`OFF_WIDTH-1:0] inStartOff,
  input  logic                  inValid,
  output logic                  inReady,
  output scanT                  scanData,
  output logic                  scanValid,
  input  logic                  scanReady
);

  localparam int EXT_PARCELS = `PARCEL_COUNT + `WINDOW_PARCELS - 1;

  logic [EXT_PARCELS-1:0][`PARCEL_WIDTH-1:0] extParcels;
  logic [EXT_PARCELS-1:0]                    extEnds;
  logic [`PARCEL_COUNT-1:0]                  prevEnd;
  logic [`PARCEL_COUNT-1:0]                  startMask;
  logic [`PARCEL_COUNT-1:0]                  jumpMask;
  classT [`PARCEL_COUNT-1:0]                 clsVec;
  scanT                                      scanNext;

  // parcels past 14 read as zero
  assign extParcels = {{((`WINDOW_PARCELS-1)*`PARCEL_WIDTH){1'b0}}, inBundle.parcels};
  assign extEnds    = {{(`WINDOW_PARCELS-1){1'b0}}, inBundle.endBits};
  assign prevEnd    = {inBundle.endBits[`PARCEL_COUNT-2:0], 1'b1}; // parcel -1 always ended

  // *************************************************************************
  // starts and per-parcel class
  // *************************************************************************

  for (genvar k = 0; k < `PARCEL_COUNT; k++) begin : gParcel
    assign startMask[k] = prevEnd[k] && (`OFF_WIDTH'(k) >= inStartOff);
    assign jumpMask[k]  = startMask[k] && clsVec[k].jump;

    predecClass uClass (
      .window  (extParcels[k +: 2]),
      .longForm(~inBundle.endBits[k]),
      .cls     (clsVec[k])
    );
  end

  always_comb begin
    scanNext.parcels   = inBundle.parcels;
    scanNext.startMask = startMask;
    scanNext.jumpMask  = jumpMask;
    for (int k = 0; k < `PARCEL_COUNT; k++) begin
      scanNext.slots[k].window     = extParcels[k +: `WINDOW_PARCELS];
      scanNext.slots[k].off        = `OFF_WIDTH'(k);
      scanNext.slots[k].lengthCode = ~extEnds[k +: `WINDOW_PARCELS];
      scanNext.slots[k].cls        = clsVec[k];
    end
    scanNext.error = (inStartOff == {`OFF_WIDTH{1'b1}}) ||
                     ($countones(startMask) > `SLOT_COUNT); // bad offset or too many
  end

  // *************************************************************************
  // stage 1 register
  // *************************************************************************

  assign inReady = !scanValid || scanReady;

  always_ff @(posedge clk) begin
    if (reset) begin
      scanValid <= 1'b0;
    end else if (inReady) begin
      scanValid <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (inValid && inReady) begin
      scanData <= scanNext;
    end
  end

  // held while stage 2 stalls
  assert property (@(posedge clk) disable iff (reset)
    scanValid && !scanReady |=> scanValid && $stable(scanData));

endmodule

//--- hw/bundleEmit.sv
`timescale 1ns/1ns
`include "predec_cfg.svh"

module bundleEmit import predecPkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  scanT      scanData,
  input  logic      scanValid,
  output logic      scanReady,
  output predecOutT outData,
  output logic      outValid,
  input  logic      outReady
);

  slotT [`SLOT_COUNT-1:0]   slotPick;
  logic [`SLOT_COUNT-1:0]   slotEnPick;
  slotT [`JUMP_COUNT-1:0]   jumpPick;
  logic [`JUMP_COUNT-1:0]   jumpEnPick;
  logic                     jumpOverflow;
  predecOutT                outNext;

  // *************************************************************************
  // instruction and jump lists
  // *************************************************************************

  slotCompact #(.itemT(slotT), .OUT_COUNT(`SLOT_COUNT)) uSlots (
    .items   (scanData.slots),
    .flags   (scanData.startMask),
    .picked  (slotPick),
    .pickedEn(slotEnPick),
    .overflow()
  );

  slotCompact #(.itemT(slotT), .OUT_COUNT(`JUMP_COUNT)) uJumps (
    .items   (scanData.slots),
    .flags   (scanData.jumpMask),
    .picked  (jumpPick),
    .pickedEn(jumpEnPick),
    .overflow(jumpOverflow)
  );

  always_comb begin
    outNext.slots        = slotPick;
    outNext.slotEn       = slotEnPick;
    outNext.jumps        = jumpPick;
    outNext.jumpEn       = jumpEnPick;
    outNext.error        = scanData.error;
    outNext.jumpOverflow = jumpOverflow; // 5 or more jumps
  end

  // *************************************************************************
  // output register
  // *************************************************************************

  assign scanReady = !outValid || outReady;

  always_ff @(posedge clk) begin
    if (reset) begin
      outValid <= 1'b0;
    end else if (scanReady) begin
      outValid <= scanValid;
    end
  end

  always_ff @(posedge clk) begin
    if (scanValid && scanReady) begin
      outData <= outNext;
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    outValid && !outReady |=> outValid && $stable(outData));

  // slots fill from slot 0 upward
  assert property (@(posedge clk) disable iff (reset)
    outValid |-> ((outData.slotEn + 1'b1) & outData.slotEn) == '0);

endmodule

//--- hw/predecTop.sv
`timescale 1ns/1ns
`include "predec_cfg.svh"

module predecTop import predecPkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  bundleT                inBundle,
  input  logic [`OFF_WIDTH-1:0] inStartOff,
  input  logic                  inValid,
  output logic                  inReady,
  output predecOutT             outData,
  output logic                  outValid,
  input  logic                  outReady
);

  scanT scanData;
  logic scanValid;
  logic scanReady;

  parcelScan uScan (
    .clk       (clk),
    .reset     (reset),
    .inBundle  (inBundle),
    .inStartOff(inStartOff),
    .inValid   (inValid),
    .inReady   (inReady),
    .scanData  (scanData),
    .scanValid (scanValid),
    .scanReady (scanReady)
  );

  bundleEmit uEmit (
    .clk      (clk),
    .reset    (reset),
    .scanData (scanData),
    .scanValid(scanValid),
    .scanReady(scanReady),
    .outData  (outData),
    .outValid (outValid),
    .outReady (outReady)
  );

endmodule

//--- verif/predecCheck.sv
`timescale 1ns/1ns
`include "predec_cfg.svh"

module predecCheck import predecPkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  bundleT                inBundle,
  input  logic [`OFF_WIDTH-1:0] inStartOff,
  input  logic                  inValid,
  input  logic                  inReady,
  input  predecOutT             outData,
  input  logic                  outValid,
  input  logic                  outReady,
  output int                    errCount,
  output int                    pendCount
);

  predecOutT expQ[$];  // one entry per accepted bundle
  predecOutT expHead;  // oldest expected output

  function automatic classT classOf(logic [15:0] p, logic longForm);
    classT      c;
    logic [7:0] op;
    c  = '0;
    op = p[7:0];
    if (!longForm) begin
      c.jump = p[5:0] >= 6'd48 && p[5:0] <= 6'd51;
      c.alu  = p[5:0] <= 6'd19 || c.jump;
    end else if (op <= 8'd31) begin
      c.mul = op[2];
      c.alu = !op[2];
    end else if (op >= 8'd40 && op <= 8'd45) begin
      c.shift = 1'b1;
    end else if (op >= 8'd46 && op <= 8'd53) begin
      c.alu = 1'b1;
    end else if (op >= 8'd64 && op <= 8'd127) begin
      c.store = op[0];
      c.load  = !op[0];
    end else if (op >= 8'd160 && op <= 8'd175) begin
      c.jump = 1'b1;
      c.alu  = 1'b1;
    end else if (op == 8'd180 || op == 8'd181) begin
      c.jump = 1'b1;
    end else if (op == 8'd182 && p[15:13] <= 3'd3) begin
      c.jump  = 1'b1;
      c.indir = p[15:13] == 3'd0 || p[15:13] == 3'd3;
      c.store = p[15:13] == 3'd1 || p[15:13] == 3'd2;
    end else begin
      c.fpu = op == 8'd240;
      c.sys = op == 8'd255;
    end
    return c;
  endfunction

  function automatic predecOutT modelBundle(bundleT b, logic [`OFF_WIDTH-1:0] off);
    predecOutT r;
    slotT      s;
    int        nStart;
    int        nJump;
    int        idx;
    r      = '0;
    nStart = 0;
    nJump  = 0;
    for (int k = 0; k < `PARCEL_COUNT; k++) begin
      if ((k == 0 || b.endBits[k-1]) && k >= off) begin
        s     = '0;
        s.off = `OFF_WIDTH'(k);
        for (int w = 0; w < `WINDOW_PARCELS; w++) begin
          idx = k + w;
          if (idx < `PARCEL_COUNT) begin
            s.window[w*`PARCEL_WIDTH +: `PARCEL_WIDTH] = b.parcels[idx];
            s.lengthCode[w] = !b.endBits[idx];
          end else begin
            s.lengthCode[w] = 1'b1; // end bit reads zero past the bundle
          end
        end
        s.cls = classOf(b.parcels[k], !b.endBits[k]);
        if (nStart < `SLOT_COUNT) begin
          r.slots[nStart]  = s;
          r.slotEn[nStart] = 1'b1;
        end
        if (s.cls.jump) begin
          if (nJump < `JUMP_COUNT) begin
            r.jumps[nJump]  = s;
            r.jumpEn[nJump] = 1'b1;
          end
          nJump++;
        end
        nStart++;
      end
    end
    r.error        = off == {`OFF_WIDTH{1'b1}} || nStart > `SLOT_COUNT;
    r.jumpOverflow = nJump > `JUMP_COUNT;
    return r;
  endfunction

  initial begin
    errCount  = 0;
    pendCount = 0;
    expHead   = '0;
  end

  always @(posedge clk) begin
    if (reset) begin
      expQ.delete();
    end else begin
      if (outValid && outReady && expQ.size() > 0) begin
        void'(expQ.pop_front());
      end
      if (inValid && inReady) begin
        expQ.push_back(modelBundle(inBundle, inStartOff));
      end
    end
    pendCount <= expQ.size();
    if (expQ.size() > 0) begin
      expHead <= expQ[0];
    end
  end

  // *************************************************************************
  // checks
  // *************************************************************************

  assert property (@(posedge clk) $past(reset) && !reset |-> !outValid)
    else begin
      errCount++;
      $display("ERROR %0t: outValid high right after reset", $time);
    end

  assert property (@(posedge clk) disable iff (reset)
    inValid && inReady && pendCount == 0 |=> !outValid ##1 outValid)
    else begin
      errCount++;
      $display("ERROR %0t: output not valid 2 cycles after acceptance", $time);
    end

  assert property (@(posedge clk) disable iff (reset)
    outValid && outReady |-> pendCount > 0)
    else begin
      errCount++;
      $display("ERROR %0t: output taken while no bundle was pending", $time);
    end

  // two bundles in flight and a stalled output fill both stages
  assert property (@(posedge clk) disable iff (reset)
    inReady == (pendCount < 2 || outReady))
    else begin
      errCount++;
      $display("ERROR %0t: inReady %b with %0d bundles pending and outReady %b",
               $time, $sampled(inReady), $sampled(pendCount), $sampled(outReady));
    end

  assert property (@(posedge clk) disable iff (reset)
    outValid && outReady && pendCount > 0 |-> outData == expHead)
    else begin
      errCount++;
      $display("ERROR %0t: output differs, slotEn %h exp %h, jumpEn %h exp %h, err %b exp %b",
               $time, $sampled(outData.slotEn), $sampled(expHead.slotEn),
               $sampled(outData.jumpEn), $sampled(expHead.jumpEn),
               $sampled(outData.error), $sampled(expHead.error));
    end

  assert property (@(posedge clk) disable iff (reset)
    outValid && !outReady |=> outValid && $stable(outData))
    else begin
      errCount++;
      $display("ERROR %0t: output changed while stalled", $time);
    end

endmodule

//--- verif/predecTb.sv
`timescale 1ns/1ns
`include "predec_cfg.svh"

module predecTb import predecPkg::*; ();

  localparam int TIMEOUT = 200;

  logic                  clk;
  logic                  reset;
  bundleT                inBundle;
  logic [`OFF_WIDTH-1:0] inStartOff;
  logic                  inValid;
  logic                  inReady;
  predecOutT             outData;
  logic                  outValid;
  logic                  outReady;
  logic                  stallOn;
  int                    errCount;
  int                    pendCount;
  int                    seed;
  int                    testNum;
  int                    failedTests;
  int                    errBefore;

  predecTop i_dut (.*);

  predecCheck uCheck (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(negedge clk) begin
    outReady = !stallOn || ($random(seed) & 3) != 0; // about one cycle in four low
  end

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  function automatic bundleT randomBundle();
    bundleT b;
    for (int k = 0; k < `PARCEL_COUNT; k++) begin
      b.parcels[k] = $random(seed);
    end
    b.endBits = $random(seed);
    b.spare   = $random(seed);
    return b;
  endfunction

  task automatic sendBundle(input bundleT b, input logic [`OFF_WIDTH-1:0] off);
    int waited;
    @(negedge clk);
    inBundle   = b;
    inStartOff = off;
    inValid    = 1'b1;
    waited     = 0;
    #1;
    while (!inReady) begin
      if (waited == TIMEOUT) abortRun("inReady stayed low, bundle was never accepted");
      @(negedge clk);
      #1;
      waited++;
    end
    @(posedge clk); // accepted here
  endtask

  task automatic finishTest(input string name);
    int waited;
    @(negedge clk);
    inValid = 1'b0;
    waited  = 0;
    while (pendCount != 0) begin
      if (waited == TIMEOUT) abortRun({"pipeline did not drain in test ", name});
      @(negedge clk);
      waited++;
    end
    testNum++;
    if (errCount == errBefore) begin
      $display("test %0d %s: passed", testNum, name);
    end else begin
      failedTests++;
      $display("test %0d %s: %0d errors", testNum, name, errCount - errBefore);
    end
    errBefore = errCount;
  endtask

  initial begin
    bundleT b;
    seed        = 95;
    reset       = 1'b1;
    inValid     = 1'b0;
    inBundle    = '0;
    inStartOff  = '0;
    outReady    = 1'b1;
    stallOn     = 1'b0;
    testNum     = 0;
    failedTests = 0;
    errBefore   = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    sendBundle(randomBundle(), 4'd0);
    finishTest("first bundle latency");

    for (int i = 0; i < 40; i++) begin
      sendBundle(randomBundle(), `OFF_WIDTH'($unsigned($random(seed)) % 15));
    end
    finishTest("random starts");

    // every long opcode, then opcode 182 with each sub kind
    for (int op = 0; op < 264; op++) begin
      b = randomBundle();
      b.parcels[0][7:0] = op < 256 ? 8'(op) : 8'd182;
      if (op >= 256) begin
        b.parcels[0][15:13] = 3'(op - 256);
      end
      b.endBits[0] = 1'b0;
      sendBundle(b, 4'd0);
    end
    for (int op = 0; op < 64; op++) begin
      b = randomBundle();
      b.parcels[0][5:0] = 6'(op);
      b.endBits[0]      = 1'b1; // short form
      sendBundle(b, 4'd0);
    end
    finishTest("class table");

    for (int n = 0; n <= 8; n++) begin
      b         = randomBundle();
      b.endBits = '1;
      for (int k = 0; k < `PARCEL_COUNT; k++) begin
        b.parcels[k][5:0] = (k % 2 == 0 && k / 2 < n) ? 6'd48 + 6'(k % 4) : 6'(k);
      end
      sendBundle(b, 4'd0);
    end
    for (int i = 0; i < 20; i++) begin
      b = randomBundle();
      for (int k = 0; k < `PARCEL_COUNT; k++) begin
        if ($random(seed) & 1) b.parcels[k][7:0] = b.endBits[k] ? 8'd49 : 8'd180;
      end
      sendBundle(b, 4'd0);
    end
    finishTest("jump list");

    b = randomBundle();
    sendBundle(b, 4'd15);
    b.endBits = '1;
    sendBundle(b, 4'd0); // 15 starts
    sendBundle(b, 4'd2); // 13 starts
    sendBundle(b, 4'd3); // exactly 12
    finishTest("error flag");

    @(posedge clk);
    stallOn = 1'b1;
    for (int i = 0; i < 60; i++) begin
      sendBundle(randomBundle(), `OFF_WIDTH'($unsigned($random(seed)) % 15));
    end
    finishTest("back-pressure");

    $display("%0d tests, %0d failed, %0d errors", testNum, failedTests, errCount);
    if (failedTests == 0 && errCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+hw
hw/predec_pkg.sv
hw/predecClass.sv
hw/slotCompact.sv
hw/parcelScan.sv
hw/bundleEmit.sv
hw/predecTop.sv
verif/predecCheck.sv
verif/predecTb.sv
